/* Bender.yml */
package:
  name: icache

sources:
  - verilog/icache_pkg.sv
  - verilog/icache_way_ram.sv
  - verilog/icache_plru.sv
  - verilog/icache_tag_match.sv
  - verilog/icache_ctrl.sv
  - verilog/icache_top.sv
  - target: test
    files:
      - tb/icache_checker.sv
      - tb/icache_tb.sv

/* list.f */
verilog/icache_pkg.sv
verilog/icache_way_ram.sv
verilog/icache_plru.sv
verilog/icache_tag_match.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
tb/icache_checker.sv
tb/icache_tb.sv

/* tb/icache_checker.sv */
`timescale 1ns/10ps

// Response checker for the instruction cache.
// Samples the DUT ports on the falling edge, where they are settled.
module icache_checker (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_ready_i,
  input  icache_pkg::cache_res_t res_i,
  input  logic                   res_ready_i,
  input  icache_pkg::mem_req_t   mem_req_i
);

  localparam int unsigned AW = icache_pkg::ADDR_W;
  localparam int unsigned OW = icache_pkg::OFF_W;

  // Wide enough for a whole response with its flags.
  typedef logic [$bits(icache_pkg::cache_res_t)-1:0] val_t;

  // One expected response per accepted request.
  typedef struct packed {
    logic [AW-1:0] addr;
    logic          miss;
  } expect_t;

  expect_t                exp_q[$];
  int                     err_cnt     = 0;
  int                     timeout_cnt = 0;
  int                     done_cnt    = 0;
  int                     flush_cnt   = 0;
  logic                   flush_seen  = 1'b0;
  logic                   stalled     = 1'b0;
  icache_pkg::cache_res_t held;

  function automatic logic [AW-1:0] align(logic [AW-1:0] addr);
    return {addr[AW-1:OW], {OW{1'b0}}};
  endfunction

  // The memory rule repeats the aligned address over the block.
  function automatic icache_pkg::blk_t mem_blk(logic [AW-1:0] addr);
    return {(icache_pkg::BLK_W / AW){align(addr)}};
  endfunction

  task automatic push_expect(input logic [AW-1:0] addr, input logic miss);
    exp_q.push_back({addr, miss});
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  task automatic note_timeout(input string what);
    timeout_cnt++;
    $display("timeout at %0t while waiting for %s", $time, what);
  endtask

  task automatic note_error(input string what);
    err_cnt++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic mismatch(input string name, input val_t exp, input val_t got);
    err_cnt++;
    $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
  endtask

  always @(negedge clk_i) begin
    expect_t e;
    if (rst_ni) begin
      // Initial flush walk takes one cycle per set.
      if (!flush_seen) begin
        if (req_ready_i) begin
          flush_seen = 1'b1;
          if (flush_cnt != icache_pkg::NUM_SET_D)
            mismatch("flush cycles", icache_pkg::NUM_SET_D, flush_cnt);
        end else begin
          flush_cnt++;
        end
      end
      // A stalled response holds still.
      if (stalled && res_i !== held)
        mismatch("res_o", held, res_i);
      if (res_i.valid && !res_ready_i && req_ready_i)
        mismatch("req_ready_o", 0, req_ready_i);
      // Lower request belongs to the oldest pending entry.
      if (mem_req_i.valid && exp_q.size() > 0 && mem_req_i.addr !== align(exp_q[0].addr))
        mismatch("mem_req_o.addr", align(exp_q[0].addr), mem_req_i.addr);
      if (res_i.valid && res_ready_i) begin
        if (exp_q.size() == 0) begin
          note_error("response arrived with no request pending");
        end else begin
          e = exp_q.pop_front();
          done_cnt++;
          if (res_i.miss !== e.miss)
            mismatch("res_o.miss", e.miss, res_i.miss);
          if (res_i.blk !== mem_blk(e.addr))
            mismatch("res_o.blk", mem_blk(e.addr), res_i.blk);
        end
      end
      stalled = res_i.valid && !res_ready_i;
      held    = res_i;
    end
  end

endmodule

/* tb/icache_tb.sv */
`timescale 1ns/10ps

// Testbench for the instruction cache.
// Lower memory model, table driven requests and consumer stalls.
module icache_tb;

  localparam int TIMEOUT = 200;
  localparam int N       = 18;

  // Address, expected miss, flush before, consumer stall cycles.
  typedef struct packed {
    logic [31:0] addr;
    logic        miss;
    logic        flush;
    logic [3:0]  stall;
  } entry_t;

  // Set 0 tags A=1000 B=2000 C=3000 D=4000 E=5000.
  // By the tree E replaces B, so C still hits and B misses.
  entry_t tbl [N] = '{
    '{32'h0000_1000, 1'b1, 1'b0, 4'd0},
    '{32'h0000_1008, 1'b0, 1'b0, 4'd0},
    '{32'h0000_2000, 1'b1, 1'b0, 4'd0},
    '{32'h0000_3000, 1'b1, 1'b0, 4'd2},
    '{32'h0000_4000, 1'b1, 1'b0, 4'd0},
    '{32'h0000_1004, 1'b0, 1'b0, 4'd3},
    '{32'h0000_5000, 1'b1, 1'b0, 4'd0},
    '{32'h0000_3000, 1'b0, 1'b0, 4'd0},
    '{32'h0000_2000, 1'b1, 1'b0, 4'd0},
    '{32'h0000_0010, 1'b1, 1'b0, 4'd0},
    '{32'h0000_0020, 1'b1, 1'b0, 4'd0},
    '{32'h0000_0014, 1'b0, 1'b0, 4'd0},
    '{32'h0000_0024, 1'b0, 1'b0, 4'd0},
    '{32'h0000_001C, 1'b0, 1'b0, 4'd0},
    '{32'h0000_002C, 1'b0, 1'b0, 4'd0},
    '{32'h0000_1000, 1'b0, 1'b0, 4'd1},
    '{32'h0000_0014, 1'b1, 1'b1, 4'd0},
    '{32'h0000_1000, 1'b1, 1'b0, 4'd0}
  };

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   flush_i;
  icache_pkg::cache_req_t req_i;
  logic                   req_ready_o;
  icache_pkg::cache_res_t res_o;
  logic                   res_ready_i;
  icache_pkg::mem_req_t   mem_req_o;
  icache_pkg::mem_res_t   mem_res_i;
  integer                 seed = 19;
  int                     stall_q[$];

  always #20 clk_i = ~clk_i;

  icache_top #(
    .NUM_SET(icache_pkg::NUM_SET_D),
    .NUM_WAY(icache_pkg::NUM_WAY_D)
  ) dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .req_i      (req_i),
    .req_ready_o(req_ready_o),
    .res_o      (res_o),
    .res_ready_i(res_ready_i),
    .mem_req_o  (mem_req_o),
    .mem_res_i  (mem_res_i)
  );

  icache_checker chk (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_ready_i(req_ready_o),
    .res_i      (res_o),
    .res_ready_i(res_ready_i),
    .mem_req_i  (mem_req_o)
  );

  // Lower memory model answering after 1 to 4 cycles.
  always begin
    int          delay;
    logic [31:0] addr;
    @(negedge clk_i);
    if (rst_ni && mem_req_o.valid) begin
      delay = 1 + ({$random(seed)} % 4);
      addr  = mem_req_o.addr;
      repeat (delay) @(posedge clk_i);
      mem_res_i.valid <= 1'b1;
      mem_res_i.blk   <= {4{addr}};
      @(posedge clk_i);
      mem_res_i.valid <= 1'b0;
    end
  end

  // Consumer stalls the oldest response for its count.
  always begin
    @(negedge clk_i);
    if (res_o.valid && res_ready_i && stall_q.size() > 0)
      void'(stall_q.pop_front());
    else if (res_o.valid && !res_ready_i && stall_q.size() > 0 && stall_q[0] > 0)
      stall_q[0] = stall_q[0] - 1;
    @(posedge clk_i);
    res_ready_i <= (stall_q.size() == 0) || (stall_q[0] == 0);
  end

  task automatic wait_drain(output logic ok);
    int n;
    n = 0;
    while (chk.pending() != 0 && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    ok = (chk.pending() == 0);
    if (!ok) chk.note_timeout("outstanding responses to complete");
  endtask

  // Returns on the falling edge before the accepting edge.
  task automatic wait_ready(output logic ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < TIMEOUT) begin
      @(negedge clk_i);
      if (req_ready_o) ok = 1'b1;
      else n++;
    end
    if (!ok) chk.note_timeout("req_ready_o to accept a request");
  endtask

  initial begin
    logic ok;
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    req_i       = '0;
    res_ready_i = 1'b1;
    mem_res_i   = '0;
    ok          = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < N && ok; i++) begin
      if (tbl[i].flush) begin
        req_i.valid <= 1'b0;
        wait_drain(ok);
        if (ok) begin
          flush_i <= 1'b1;
          @(posedge clk_i);
          flush_i <= 1'b0;
        end
      end
      if (ok) begin
        req_i.valid <= 1'b1;
        req_i.addr  <= tbl[i].addr;
        wait_ready(ok);
        if (ok) begin
          chk.push_expect(tbl[i].addr, tbl[i].miss);
          stall_q.push_back(tbl[i].stall);
          @(posedge clk_i);
        end
      end
    end
    req_i.valid <= 1'b0;
    if (ok) wait_drain(ok);
    $display("errors: %0d, timeouts: %0d, responses checked: %0d",
             chk.err_cnt, chk.timeout_cnt, chk.done_cnt);
    if (chk.err_cnt == 0 && chk.timeout_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verilog/icache_ctrl.sv */
`timescale 1ns/10ps

// Cache control.
// Holds the compare-stage request, walks the flush and drives the fill.
module icache_ctrl #(
  parameter int unsigned NUM_SET = icache_pkg::NUM_SET_D,
  parameter int unsigned NUM_WAY = icache_pkg::NUM_WAY_D
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  icache_pkg::cache_req_t       req_i,
  output logic                         req_ready_o,
  input  logic                         res_ready_i,
  output logic                         res_valid_o,
  output logic                         res_miss_o,
  output icache_pkg::mem_req_t         mem_req_o,
  input  logic                         mem_valid_i,
  input  logic                         hit_i,
  input  logic [NUM_WAY-1:0]           hit_way_i,
  input  logic [NUM_WAY-1:0]           victim_i,
  output logic [icache_pkg::TAG_W-1:0] tag_o,
  output logic [icache_pkg::IDX_W-1:0] idx_o,
  output logic [NUM_WAY-1:0]           tag_we_o,
  output logic [NUM_WAY-1:0]           data_we_o,
  output icache_pkg::tag_entry_t       tag_wdata_o,
  output logic                         plru_touch_o,
  output logic [NUM_WAY-1:0]           plru_way_o,
  output logic                         plru_clear_o
);

  localparam int unsigned IW = icache_pkg::IDX_W;

  // Flush walker.
  logic                              flush_q;
  logic [IW-1:0]                     flush_cnt_q;
  // Request in the compare stage.
  logic                              req_valid_q;
  logic [icache_pkg::ADDR_W-1:0]     req_addr_q;
  // Lower request issued and not yet answered.
  logic                              mem_pend_q;
  // Fill done but the response not yet taken.
  logic                              fill_done_q;
  logic                              miss;
  logic                              fill;
  logic                              res_done;
  logic                              hit_res;
  logic                              accept;

  // A miss waits for the lower memory.
  assign miss     = req_valid_q && !hit_i && !fill_done_q;
  // The fill cycle is the one where the block arrives.
  assign fill     = miss && mem_valid_i;
  assign hit_res  = req_valid_q && hit_i && !fill_done_q;

  assign res_valid_o = req_valid_q && (hit_i || fill || fill_done_q);
  // After a stalled fill the banks hit, but the response stays a miss.
  assign res_miss_o  = fill_done_q || (req_valid_q && !hit_i);
  assign res_done    = res_valid_o && res_ready_i;

  // Take a new request when the stage is empty or draining a hit.
  // No request while a flush runs or waits to start.
  assign req_ready_o = !flush_q && !flush_i && (!req_valid_q || (res_done && !fill));
  assign accept      = req_i.valid && req_ready_o;

  assign mem_req_o.valid = miss;
  assign mem_req_o.addr  = {req_addr_q[icache_pkg::ADDR_W-1:icache_pkg::OFF_W],
                            {icache_pkg::OFF_W{1'b0}}};

  assign tag_o = req_addr_q[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];

  // Bank index.
  // Hold the compare-stage set unless a new request may enter.
  assign idx_o = flush_q     ? flush_cnt_q :
                 req_ready_o ? req_i.addr[icache_pkg::OFF_W +: IW] :
                               req_addr_q[icache_pkg::OFF_W +: IW];

  // Fill writes tag and data into the victim way.
  assign data_we_o = fill ? victim_i : '0;
  // Flush invalidates all ways of the walked set.
  assign tag_we_o  = flush_q ? '1 : data_we_o;

  assign tag_wdata_o.valid = !flush_q;
  assign tag_wdata_o.tag   = flush_q ? '0 : tag_o;

  // Hits update the tree once, when the response is taken.
  assign plru_touch_o = fill || (hit_res && res_ready_i);
  assign plru_way_o   = fill ? victim_i : hit_way_i;
  assign plru_clear_o = flush_q;

  // Flush runs after reset and on request once the stage is empty.
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      flush_q     <= 1'b1;
      flush_cnt_q <= '0;
    end else if (flush_q) begin
      if (flush_cnt_q == IW'(NUM_SET - 1)) begin
        flush_q     <= 1'b0;
        flush_cnt_q <= '0;
      end else begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
    end else if (flush_i && !req_valid_q) begin
      flush_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else if (accept) begin
      req_valid_q <= 1'b1;
    end else if (res_done) begin
      req_valid_q <= 1'b0;
    end
  end

  // Address of the compare-stage request.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_addr_q <= req_i.addr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mem_pend_q  <= 1'b0;
      fill_done_q <= 1'b0;
    end else begin
      mem_pend_q <= mem_req_o.valid && !mem_valid_i;
      if (fill && !res_ready_i) begin
        fill_done_q <= 1'b1;
      end else if (res_ready_i) begin
        fill_done_q <= 1'b0;
      end
    end
  end

  // The lower request holds still from issue up to its fill.
  a_mem_req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni) mem_pend_q |-> $stable(mem_req_o)
  ) else $error("mem_req_o changed before the fill");

endmodule

/* verilog/icache_pkg.sv */
// Shared sizes and port types for the instruction cache.
package icache_pkg;

  // Byte address width.
  localparam int unsigned ADDR_W = 32;

  // Cache block width in bits.
  // 128 bits hold 16 bytes.
  localparam int unsigned BLK_W = 128;

  // Default geometry.
  // The way count must be a power of two.
  localparam int unsigned NUM_SET_D = 8;
  localparam int unsigned NUM_WAY_D = 4;

  // Address fields, from low to high.
  // Byte offset inside a block.
  localparam int unsigned OFF_W = $clog2(BLK_W / 8);
  // Set index.
  localparam int unsigned IDX_W = $clog2(NUM_SET_D);
  // Remaining upper bits form the tag.
  localparam int unsigned TAG_W = ADDR_W - IDX_W - OFF_W;

  // One cache block.
  typedef logic [BLK_W-1:0] blk_t;

  // Tag bank entry.
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  // Request from the fetch side.
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } cache_req_t;

  // Response to the fetch side.
  // Miss marks a block that came from the lower memory.
  typedef struct packed {
    logic valid;
    logic miss;
    blk_t blk;
  } cache_res_t;

  // Line fill request to the lower memory.
  // The address is block aligned.
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } mem_req_t;

  // Line fill data, valid for a single cycle.
  typedef struct packed {
    logic valid;
    blk_t blk;
  } mem_res_t;

endpackage

/* verilog/icache_plru.sv */
`timescale 1ns/10ps

// Tree pseudo-LRU state for every set.
// Nodes are stored heap style, node n has children 2n+1 and 2n+2.
// A node at 0 sends the victim search to the lower half.
module icache_plru #(
  parameter int unsigned NUM_SET = icache_pkg::NUM_SET_D,
  parameter int unsigned NUM_WAY = icache_pkg::NUM_WAY_D
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [icache_pkg::IDX_W-1:0] idx_i,
  input  logic                         touch_i,
  input  logic [NUM_WAY-1:0]           touch_way_i,
  input  logic                         clear_i,
  output logic [NUM_WAY-1:0]           victim_o
);

  // Tree depth.
  localparam int unsigned LVL = $clog2(NUM_WAY);

  typedef logic [NUM_WAY-2:0] node_t;

  node_t                        node_mem [NUM_SET];
  // Registered read index, same latency as the banks.
  logic [icache_pkg::IDX_W-1:0] idx_q;
  node_t                        node_rd;
  logic [LVL-1:0]               touch_enc;
  logic [LVL-1:0]               victim_enc;

  // Follow the nodes from the root down to a leaf.
  function automatic logic [LVL-1:0] walk_victim(node_t nodes);
    int unsigned    n;
    logic [LVL-1:0] way;
    n   = 0;
    way = '0;
    for (int unsigned l = 0; l < LVL; l++) begin
      way[LVL-1-l] = nodes[n];
      n = 2 * n + 1 + nodes[n];
    end
    return way;
  endfunction

  // Make every node on the path point away from the touched way.
  function automatic node_t touch_path(node_t nodes, logic [LVL-1:0] way);
    int unsigned n;
    node_t       upd;
    n   = 0;
    upd = nodes;
    for (int unsigned l = 0; l < LVL; l++) begin
      upd[n] = ~way[LVL-1-l];
      n = 2 * n + 1 + way[LVL-1-l];
    end
    return upd;
  endfunction

  // Binary number of the touched way.
  always_comb begin
    touch_enc = '0;
    for (int unsigned i = 0; i < NUM_WAY; i++) begin
      if (touch_way_i[i]) begin
        touch_enc = LVL'(i);
      end
    end
  end

  assign node_rd    = node_mem[idx_q];
  assign victim_enc = walk_victim(node_rd);

  always_comb begin
    victim_o             = '0;
    victim_o[victim_enc] = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else begin
      idx_q <= idx_i;
    end
  end

  // Clear follows the flush index directly.
  // Touch targets the set held in the compare stage.
  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      node_mem[idx_i] <= '0;
    end else if (touch_i) begin
      node_mem[idx_q] <= touch_path(node_rd, touch_enc);
    end
  end

  // A hit or a fill always names exactly one way.
  a_touch_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) touch_i |-> $onehot(touch_way_i)
  ) else $error("plru touch with way vector %b", touch_way_i);

endmodule

/* verilog/icache_tag_match.sv */
`timescale 1ns/10ps

// Tag compare for all ways of one set.
// Purely combinational, fed by the bank read ports.
module icache_tag_match #(
  parameter int unsigned NUM_WAY = icache_pkg::NUM_WAY_D
) (
  input  icache_pkg::tag_entry_t [NUM_WAY-1:0] tags_i,
  input  icache_pkg::blk_t       [NUM_WAY-1:0] blks_i,
  input  logic [icache_pkg::TAG_W-1:0]         tag_i,
  output logic                                 hit_o,
  output logic [NUM_WAY-1:0]                   hit_way_o,
  output icache_pkg::blk_t                     blk_o
);

  // Per way hit, only valid entries count.
  always_comb begin
    for (int unsigned i = 0; i < NUM_WAY; i++) begin
      hit_way_o[i] = tags_i[i].valid && (tags_i[i].tag == tag_i);
    end
  end

  assign hit_o = |hit_way_o;

  // AND-OR select of the hit block.
  // Zero when nothing hits
  always_comb begin
    blk_o = '0;
    for (int unsigned i = 0; i < NUM_WAY; i++) begin
      blk_o = blk_o | (blks_i[i] & {icache_pkg::BLK_W{hit_way_o[i]}});
    end
  end

  // Fills only go to the victim after a miss.
  // A tag can therefore live in one way of a set at most.
  // Before the first flush the banks still read unknown values.
  a_one_hit: assert final ($isunknown(hit_way_o) || $onehot0(hit_way_o))
    else $error("tag match with several hitting ways %b", hit_way_o);

endmodule

/* verilog/icache_top.sv */
`timescale 1ns/10ps

// Instruction cache top.
// Controller, per way tag and data banks, tag matcher and PLRU tree.
module icache_top #(
  parameter int unsigned NUM_SET = icache_pkg::NUM_SET_D,
  parameter int unsigned NUM_WAY = icache_pkg::NUM_WAY_D
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  icache_pkg::cache_req_t req_i,
  output logic                   req_ready_o,
  output icache_pkg::cache_res_t res_o,
  input  logic                   res_ready_i,
  output icache_pkg::mem_req_t   mem_req_o,
  input  icache_pkg::mem_res_t   mem_res_i
);

  // Bank control from the controller.
  logic [icache_pkg::IDX_W-1:0]          idx;
  logic [icache_pkg::TAG_W-1:0]          tag;
  logic [NUM_WAY-1:0]                    tag_we;
  logic [NUM_WAY-1:0]                    data_we;
  icache_pkg::tag_entry_t                tag_wdata;
  // Bank read data.
  icache_pkg::tag_entry_t [NUM_WAY-1:0]  tags;
  icache_pkg::blk_t       [NUM_WAY-1:0]  blks;
  // Match results.
  logic                                  hit;
  logic [NUM_WAY-1:0]                    hit_way;
  icache_pkg::blk_t                      match_blk;
  // Replacement tree.
  logic [NUM_WAY-1:0]                    victim;
  logic                                  plru_touch;
  logic [NUM_WAY-1:0]                    plru_way;
  logic                                  plru_clear;
  // Response flags.
  logic                                  res_valid;
  logic                                  res_miss;

  icache_ctrl #(
    .NUM_SET(NUM_SET),
    .NUM_WAY(NUM_WAY)
  ) u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .res_ready_i (res_ready_i),
    .res_valid_o (res_valid),
    .res_miss_o  (res_miss),
    .mem_req_o   (mem_req_o),
    .mem_valid_i (mem_res_i.valid),
    .hit_i       (hit),
    .hit_way_i   (hit_way),
    .victim_i    (victim),
    .tag_o       (tag),
    .idx_o       (idx),
    .tag_we_o    (tag_we),
    .data_we_o   (data_we),
    .tag_wdata_o (tag_wdata),
    .plru_touch_o(plru_touch),
    .plru_way_o  (plru_way),
    .plru_clear_o(plru_clear)
  );

  // One tag bank and one data bank per way.
  for (genvar w = 0; w < NUM_WAY; w++) begin : g_way
    icache_way_ram #(
      .NUM_SET  (NUM_SET),
      .payload_t(icache_pkg::tag_entry_t)
    ) u_tag_ram (
      .clk_i  (clk_i),
      .idx_i  (idx),
      .we_i   (tag_we[w]),
      .wdata_i(tag_wdata),
      .rdata_o(tags[w])
    );

    // Data banks only take fill blocks.
    icache_way_ram #(
      .NUM_SET  (NUM_SET),
      .payload_t(icache_pkg::blk_t)
    ) u_data_ram (
      .clk_i  (clk_i),
      .idx_i  (idx),
      .we_i   (data_we[w]),
      .wdata_i(mem_res_i.blk),
      .rdata_o(blks[w])
    );
  end

  icache_tag_match #(
    .NUM_WAY(NUM_WAY)
  ) u_match (
    .tags_i   (tags),
    .blks_i   (blks),
    .tag_i    (tag),
    .hit_o    (hit),
    .hit_way_o(hit_way),
    .blk_o    (match_blk)
  );

  icache_plru #(
    .NUM_SET(NUM_SET),
    .NUM_WAY(NUM_WAY)
  ) u_plru (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .idx_i      (idx),
    .touch_i    (plru_touch),
    .touch_way_i(plru_way),
    .clear_i    (plru_clear),
    .victim_o   (victim)
  );

  // The fill block bypasses the banks in its own cycle.
  assign res_o.valid = res_valid;
  assign res_o.miss  = res_miss;
  assign res_o.blk   = (res_miss && mem_res_i.valid) ? mem_res_i.blk : match_blk;

endmodule

/* verilog/icache_way_ram.sv */
`timescale 1ns/10ps

// Single-port bank for one way.
// Used for both the tag entries and the data blocks.
module icache_way_ram #(
  parameter int unsigned NUM_SET = icache_pkg::NUM_SET_D,
  parameter type payload_t = logic
) (
  input  logic                         clk_i,
  input  logic [icache_pkg::IDX_W-1:0] idx_i,
  input  logic                         we_i,
  input  payload_t                     wdata_i,
  output payload_t                     rdata_o
);

  // Storage array, one entry per set.
  payload_t mem [NUM_SET];

  // Synchronous read with one cycle latency.
  // A write also shows up on the read port in the next cycle,
  // so a held index sees the freshly filled line.
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[idx_i] <= wdata_i;
      rdata_o    <= wdata_i;
    end else begin
      rdata_o <= mem[idx_i];
    end
  end

  // The controller must never write past the last set.
  // NUM_SET below 2**IDX_W leaves unused codes.
  a_idx_range: assert property (
    @(posedge clk_i) we_i |-> (idx_i < NUM_SET)
  ) else $error("way_ram write to index %0d beyond %0d sets", idx_i, NUM_SET);

endmodule
